/* Makefile */
# Verilator build and run for the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= fetch_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard bench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* bench/fetch_ref.svh */
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

// host-written instructions, one entry per word of the memory
logic [LEN_INST-1:0] model_mem [MEM_LINES*FETCH_PARA];
logic model_mode;
logic [LEN_WORD-1:0] model_addr;

// line bits plus the slot bit of a pc
function automatic int word_index(input logic [LEN_WORD-1:0] addr);
    return int'(addr[LEN_MEMISTR_ADDR+LOG_FETCH_PARA+1:2]);
endfunction

function automatic logic [LEN_INST-1:0] expected_instr(input logic [LEN_WORD-1:0] addr);
    return model_mem[word_index(addr)];
endfunction

function automatic logic apb_mapped(input logic [LEN_APB_ADDR-1:0] offset);
    return (offset == REG_CTRL) || (offset == REG_ADDR) || (offset == REG_DATA);
endfunction

function automatic logic [LEN_WORD-1:0] expected_prdata(input logic [LEN_APB_ADDR-1:0] offset);
    if (offset == REG_CTRL) begin
        return LEN_WORD'(model_mode);
    end
    if (offset == REG_ADDR) begin
        return model_addr;
    end
    return '0;
endfunction

// register and memory effects of one apb write
function automatic void model_write(input logic [LEN_APB_ADDR-1:0] offset,
                                    input logic [LEN_WORD-1:0] data);
    if (offset == REG_CTRL) begin
        model_mode = data[0];
    end else if (offset == REG_ADDR) begin
        model_addr = data;
    end else if (offset == REG_DATA) begin
        // memory only changes in load mode
        if (model_mode) begin
            model_mem[word_index(model_addr)] = data;
        end
        model_addr = model_addr + 32'd4;
    end
endfunction

`endif

/* bench/tb_fetch_top.sv */
`timescale 1ns/10ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int LOAD_WORDS = 32;
    localparam int TIMEOUT_CYCLES = 40;

    logic clk;
    logic arst_n;
    logic [DECODE_PARA-1:0] order;
    logic [DECODE_PARA-1:0] done;
    logic [DECODE_PARA*LEN_WORD-1:0] pc;
    logic [DECODE_PARA*LEN_INST-1:0] instr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [LEN_APB_ADDR-1:0] paddr;
    logic [LEN_WORD-1:0] pwdata;
    logic [LEN_WORD-1:0] prdata;
    logic pready;
    logic pslverr;
    integer seed;
    int mismatches;
    int failures;
    int transfers;

    `include "fetch_ref.svh"

    fetch_top dut (
        .clk(clk), .arst_n(arst_n),
        .order(order), .done(done), .pc(pc), .instr(instr),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // every completed transfer against the model
    always @(negedge clk) begin
        if (arst_n) begin
            for (int i = 0; i < DECODE_PARA; i++) begin
                if (done[i] && !order[i]) begin
                    failures++;
                    $display("ERROR at %0t: lane %0d done without order", $time, i);
                end
                if (order[i] && done[i]) begin
                    transfers++;
                    if (instr[i*LEN_INST +: LEN_INST]
                            !== expected_instr(pc[i*LEN_WORD +: LEN_WORD])) begin
                        mismatches++;
                        $display("MISMATCH at %0t: instr[%0d] got %h expected %h", $time, i,
                                 instr[i*LEN_INST +: LEN_INST],
                                 expected_instr(pc[i*LEN_WORD +: LEN_WORD]));
                    end
                end
            end
        end
    end

    // starts and ends on a rising edge
    task automatic apb_access(input logic write, input logic [LEN_APB_ADDR-1:0] offset,
                              input logic [LEN_WORD-1:0] data);
        logic [LEN_WORD-1:0] expect_rd;
        expect_rd = expected_prdata(offset);
        #2;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = offset;
        pwdata = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #10;
        if (pready !== 1'b1) begin
            mismatches++;
            $display("MISMATCH at %0t: pready got %b expected 1", $time, pready);
        end
        if (pslverr !== !apb_mapped(offset)) begin
            mismatches++;
            $display("MISMATCH at %0t: pslverr got %b expected %b", $time, pslverr,
                     !apb_mapped(offset));
        end
        if (!write && prdata !== expect_rd) begin
            mismatches++;
            $display("MISMATCH at %0t: prdata got %h expected %h", $time, prdata, expect_rd);
        end
        @(posedge clk);
        if (write) begin
            model_write(offset, data);
        end
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        @(posedge clk);
    endtask

    // ends on the transfer edge with order still high
    task automatic fetch_one(input int lane, input logic [LEN_WORD-1:0] addr,
                             input logic expect_done, output int cycles);
        #2;
        pc[lane*LEN_WORD +: LEN_WORD] = addr;
        order[lane] = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!done[lane] && cycles < TIMEOUT_CYCLES) begin
            cycles++;
            @(negedge clk);
        end
        if (expect_done && !done[lane]) begin
            failures++;
            $display("ERROR at %0t: lane %0d pc %h never done", $time, lane, addr);
        end
        if (!expect_done && done[lane]) begin
            failures++;
            $display("ERROR at %0t: lane %0d pc %h done in load mode", $time, lane, addr);
        end
        @(posedge clk);
    endtask

    task automatic release_lanes();
        #2;
        order = '0;
        @(posedge clk);
    endtask

    task automatic fetch_pair(input logic [LEN_WORD-1:0] pc0, input logic [LEN_WORD-1:0] pc1);
        logic [DECODE_PARA-1:0] pending;
        int cycles;
        #2;
        pc = {pc1, pc0};
        order = 2'b11;
        pending = 2'b11;
        cycles = 0;
        while (pending != '0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            pending = pending & ~done;
            @(posedge clk);
            #2;
            order = pending;
            cycles++;
        end
        if (pending != '0) begin
            failures++;
            $display("ERROR at %0t: lanes %b of pair %h %h never done", $time, pending, pc0, pc1);
        end
        order = '0;
        @(posedge clk);
    endtask

    function automatic logic [LEN_WORD-1:0] random_pc();
        return LEN_WORD'(({$random(seed)} % LOAD_WORDS) * 4);
    endfunction

    initial begin
        logic [LEN_WORD-1:0] a;
        logic [LEN_WORD-1:0] b;
        int cycles;
        seed = 32'h3f82;
        arst_n = 1'b0;
        order = '0;
        pc = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        model_mode = 1'b0;
        model_addr = '0;
        mismatches = 0;
        failures = 0;
        transfers = 0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        if (done !== '0 || pslverr !== 1'b0) begin
            mismatches++;
            $display("MISMATCH at %0t: done/pslverr got %b/%b expected 00/0", $time, done,
                     pslverr);
        end
        @(posedge clk);
        apb_access(1'b0, REG_CTRL, '0);
        apb_access(1'b0, REG_ADDR, '0);

        // register access
        apb_access(1'b1, REG_ADDR, $random(seed));
        apb_access(1'b0, REG_ADDR, '0);
        apb_access(1'b1, REG_CTRL, $random(seed) | 32'h1);
        apb_access(1'b0, REG_CTRL, '0);
        for (int w = 0; w < 3; w++) begin
            apb_access(1'b1, REG_DATA, $random(seed));
            apb_access(1'b0, REG_ADDR, '0);
        end
        apb_access(1'b0, REG_DATA, '0);
        apb_access(1'b1, 4'hc, $random(seed));
        apb_access(1'b0, 4'h2, '0);

        // program load then single-lane walk
        apb_access(1'b1, REG_ADDR, '0);
        for (int w = 0; w < LOAD_WORDS; w++) begin
            apb_access(1'b1, REG_DATA, $random(seed));
        end
        apb_access(1'b1, REG_CTRL, '0);
        for (int w = 0; w < LOAD_WORDS; w++) begin
            fetch_one(0, LEN_WORD'(w * 4), 1'b1, cycles);
            release_lanes();
        end

        // both lanes, same line on even rounds
        for (int n = 0; n < 24; n++) begin
            a = random_pc();
            b = (n % 2 == 0) ? (a ^ 32'h4) : random_pc();
            fetch_pair(a, b);
        end

        // repeated pc must hit in its first cycle
        for (int n = 0; n < 4; n++) begin
            a = random_pc();
            fetch_one(0, a, 1'b1, cycles);
            release_lanes();
            fetch_one(0, a, 1'b1, cycles);
            if (cycles != 0) begin
                failures++;
                $display("ERROR at %0t: repeated pc %h waited %0d cycles", $time, a, cycles);
            end
            release_lanes();
        end

        // lines about to be overwritten are cached first
        for (int w = 0; w < 8; w++) begin
            fetch_one(0, LEN_WORD'(w * 4), 1'b1, cycles);
            release_lanes();
        end

        // reload part of the program
        apb_access(1'b1, REG_CTRL, 32'h1);
        fetch_one(0, 32'h8, 1'b0, cycles);
        release_lanes();
        fetch_one(1, 32'h14, 1'b0, cycles);
        release_lanes();
        apb_access(1'b1, REG_ADDR, '0);
        for (int w = 0; w < 8; w++) begin
            apb_access(1'b1, REG_DATA, $random(seed));
        end
        apb_access(1'b1, REG_CTRL, '0);
        for (int w = 0; w < 8; w++) begin
            fetch_one(w % 2, LEN_WORD'(w * 4), 1'b1, cycles);
            release_lanes();
        end

        $display("transfers %0d, mismatches %0d, other errors %0d", transfers, mismatches,
                 failures);
        if (mismatches == 0 && failures == 0 && transfers > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* fetch_top.f */
verilog/fetch_pkg.sv
verilog/imem_if.sv
verilog/load_if.sv
verilog/fetch_timing.sv
verilog/line_cache.sv
verilog/fetch.sv
verilog/instr_mem.sv
verilog/prog_loader.sv
verilog/fetch_top.sv
+incdir+bench
bench/tb_fetch_top.sv

/* verilog/fetch.sv */
`timescale 1ns/10ps

module fetch (
    input  logic clk,
    input  logic arst_n,
    input  logic [fetch_pkg::DECODE_PARA-1:0] order,
    input  logic [fetch_pkg::DECODE_PARA*fetch_pkg::LEN_WORD-1:0] pc,
    output logic [fetch_pkg::DECODE_PARA-1:0] done,
    output logic [fetch_pkg::DECODE_PARA*fetch_pkg::LEN_INST-1:0] instr,
    imem_if.fetch mem,
    load_if.fetch load
);
    import fetch_pkg::*;

    logic [DECODE_PARA-1:0] lane_req;
    logic [DECODE_PARA-1:0][LEN_MEMISTR_ADDR-1:0] lane_addr;
    logic [DECODE_PARA-1:0][LOG_FETCH_PARA-1:0] lane_slot;
    logic [NUM_LOOKUP-1:0][LEN_LINE-1:0] look_line;
    logic [FETCH_PREDICT_SIZE-1:0][LEN_MEMISTR_ADDR-1:0] cand_addr;
    logic [FETCH_PREDICT_SIZE-1:0] cand_cached;
    logic [FETCH_PREDICT_SIZE-1:0] cand_flight;
    logic [FETCH_PREDICT_SIZE-1:0] cand_need;
    logic miss;
    logic [LEN_MEMISTR_ADDR-1:0] miss_addr;
    logic miss_flight;
    logic miss_need;
    logic [LEN_MEMISTR_ADDR-1:0] base;
    logic [LEN_MEMISTR_ADDR-1:0] last_found;
    logic [LEN_MEMISTR_ADDR-1:0] next_last;
    logic pick_valid;
    logic [LEN_MEMISTR_ADDR-1:0] pick_addr;
    logic access_valid;
    logic [LEN_MEMISTR_ADDR-1:0] access_addr;
    logic next_valid;
    logic [LEN_MEMISTR_ADDR-1:0] next_addr;
    logic [FETCH_PARA-1:0] next_wen;
    logic mem_done;
    logic [LEN_MEMISTR_ADDR-1:0] mem_done_addr;
    logic fill_valid;
    logic [LEN_MEMISTR_ADDR-1:0] fill_key;
    logic [LEN_LINE-1:0] fill_line;

    // no lane is served during program load
    assign lane_req = order & ~{DECODE_PARA{load.mode}};

    for (genvar i = 0; i < DECODE_PARA; i++) begin : g_lane
        assign lane_addr[i] = pc[i*LEN_WORD+LINE_LSB +: LEN_MEMISTR_ADDR];
        assign lane_slot[i] = pc[i*LEN_WORD+2 +: LOG_FETCH_PARA];
        // slot 0 lives in the upper half
        assign instr[i*LEN_INST +: LEN_INST] =
            look_line[i][(FETCH_PARA-1-lane_slot[i])*LEN_INST +: LEN_INST];
    end

    line_cache #(.PORTS(NUM_LOOKUP)) u_cache (
        .clk(clk), .arst_n(arst_n), .flush(load.mode),
        .fill_valid(fill_valid), .fill_key(fill_key), .fill_line(fill_line),
        .look_valid({{FETCH_PREDICT_SIZE{1'b1}}, lane_req}),
        .look_key({cand_addr, lane_addr}),
        .hit({cand_cached, done}), .look_line(look_line)
    );

    fetch_timing #(.FIND_PARA(NUM_FIND)) u_timing (
        .clk(clk), .arst_n(arst_n), .order(access_valid), .done(mem_done),
        .a_inst_fetch_in(access_addr), .a_inst_fetch_out(mem_done_addr),
        .find_addr({cand_addr, miss_addr}), .found({cand_flight, miss_flight})
    );

    always_comb begin
        miss = 1'b0;
        miss_addr = lane_addr[0];
        next_last = last_found;
        // lowest missing lane wins
        for (int i = DECODE_PARA - 1; i >= 0; i--) begin
            if (lane_req[i] && !done[i]) begin
                miss = 1'b1;
                miss_addr = lane_addr[i];
            end
        end
        for (int i = 0; i < DECODE_PARA; i++) begin
            if (done[i]) begin
                next_last = lane_addr[i];
            end
        end
    end

    assign base = miss ? miss_addr : next_last;
    assign miss_need = miss & ~miss_flight;
    assign cand_need = ~(cand_cached | cand_flight);

    always_comb begin
        pick_valid = 1'b0;
        pick_addr = cand_addr[0];
        for (int i = FETCH_PREDICT_SIZE - 1; i >= 0; i--) begin
            cand_addr[i] = base + LEN_MEMISTR_ADDR'(i);
            if (cand_need[i]) begin
                pick_valid = 1'b1;
                pick_addr = cand_addr[i];
            end
        end
        for (int s = 0; s < FETCH_PARA; s++) begin
            next_wen[FETCH_PARA-1-s] = load.mode & load.order
                & (load.pc[2 +: LOG_FETCH_PARA] == LOG_FETCH_PARA'(s));
        end
    end

    assign next_valid = ~load.mode & (miss_need | pick_valid);
    assign next_addr = load.mode ? load.pc[LINE_LSB +: LEN_MEMISTR_ADDR]
                     : miss_need ? miss_addr : pick_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            access_valid <= 1'b0;
            fill_valid <= 1'b0;
            last_found <= '0;
            mem.wen <= '0;
        end else begin
            access_valid <= next_valid;
            fill_valid <= mem_done;
            last_found <= next_last;
            mem.wen <= next_wen;
        end
    end

    always_ff @(posedge clk) begin
        access_addr <= next_addr;
        fill_key <= mem_done_addr;
        fill_line <= mem.rdata;
        mem.wdata <= {FETCH_PARA{load.data}};
    end

    assign mem.addr = access_addr;

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    // data path widths
    localparam int LEN_WORD = 32;
    localparam int LEN_INST = 32;

    // line geometry
    localparam int LOG_FETCH_PARA = 1;
    localparam int FETCH_PARA = 2 ** LOG_FETCH_PARA;
    localparam int LEN_LINE = LEN_INST * FETCH_PARA;

    // pc bit where the line address starts, above byte and slot bits
    localparam int LINE_LSB = LOG_FETCH_PARA + 2;

    // instruction memory
    localparam int LEN_MEMISTR_ADDR = 8;
    localparam int MEM_LINES = 2 ** LEN_MEMISTR_ADDR;

    // lookup lanes and cache
    localparam int DECODE_PARA = 2;
    localparam int LOG_DEPTH_FETCH_CACHE = 3;
    localparam int DEPTH_FETCH_CACHE = 2 ** LOG_DEPTH_FETCH_CACHE;
    localparam int FETCH_PREDICT_SIZE = 3;

    // cache ports are the lanes plus the candidates
    localparam int NUM_LOOKUP = DECODE_PARA + FETCH_PREDICT_SIZE;
    // in-flight search covers the candidates plus the missing lane
    localparam int NUM_FIND = FETCH_PREDICT_SIZE + 1;

    // apb program-load registers
    localparam int LEN_APB_ADDR = 4;
    localparam logic [LEN_APB_ADDR-1:0] REG_CTRL = 4'h0;
    localparam logic [LEN_APB_ADDR-1:0] REG_ADDR = 4'h4;
    localparam logic [LEN_APB_ADDR-1:0] REG_DATA = 4'h8;

endpackage

/* verilog/fetch_timing.sv */
`timescale 1ns/10ps

module fetch_timing #(
    parameter int FIND_PARA = 1
) (
    input  logic clk,
    input  logic arst_n,
    input  logic order,
    output logic done,
    input  logic [fetch_pkg::LEN_MEMISTR_ADDR-1:0] a_inst_fetch_in,
    output logic [fetch_pkg::LEN_MEMISTR_ADDR-1:0] a_inst_fetch_out,
    input  logic [FIND_PARA-1:0][fetch_pkg::LEN_MEMISTR_ADDR-1:0] find_addr,
    output logic [FIND_PARA-1:0] found
);
    import fetch_pkg::*;

    logic stage1;
    logic stage2;
    logic [LEN_MEMISTR_ADDR-1:0] a_inst1;
    logic [LEN_MEMISTR_ADDR-1:0] a_inst2;

    // two stages, matching the memory read latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage1 <= 1'b0;
            stage2 <= 1'b0;
        end else begin
            stage1 <= order;
            stage2 <= stage1;
        end
    end

    always_ff @(posedge clk) begin
        a_inst1 <= a_inst_fetch_in;
        a_inst2 <= a_inst1;
    end

    assign done = stage2;
    assign a_inst_fetch_out = a_inst2;

    // issuing stage counts as in flight too
    for (genvar i = 0; i < FIND_PARA; i++) begin : g_find
        assign found[i] = ((find_addr[i] == a_inst_fetch_in) & order)
                        | ((find_addr[i] == a_inst1) & stage1)
                        | ((find_addr[i] == a_inst2) & stage2);
    end

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top (
    input  logic clk,
    input  logic arst_n,
    // fetch lanes
    input  logic [fetch_pkg::DECODE_PARA-1:0] order,
    output logic [fetch_pkg::DECODE_PARA-1:0] done,
    input  logic [fetch_pkg::DECODE_PARA*fetch_pkg::LEN_WORD-1:0] pc,
    output logic [fetch_pkg::DECODE_PARA*fetch_pkg::LEN_INST-1:0] instr,
    // apb program load
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [fetch_pkg::LEN_APB_ADDR-1:0] paddr,
    input  logic [fetch_pkg::LEN_WORD-1:0] pwdata,
    output logic [fetch_pkg::LEN_WORD-1:0] prdata,
    output logic pready,
    output logic pslverr
);

    imem_if u_imem_if ();
    load_if u_load_if ();

    prog_loader u_loader (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .load(u_load_if.loader)
    );

    fetch u_fetch (
        .clk(clk), .arst_n(arst_n),
        .order(order), .pc(pc), .done(done), .instr(instr),
        .mem(u_imem_if.fetch),
        .load(u_load_if.fetch)
    );

    instr_mem u_mem (
        .clk(clk),
        .mem(u_imem_if.memory)
    );

endmodule

/* verilog/imem_if.sv */
`timescale 1ns/10ps

interface imem_if;
    import fetch_pkg::*;

    // line address, shared by reads and load writes
    logic [LEN_MEMISTR_ADDR-1:0] addr;
    // one enable per instruction slot
    logic [FETCH_PARA-1:0] wen;
    logic [LEN_LINE-1:0] rdata;
    logic [LEN_LINE-1:0] wdata;

    modport fetch (
        output addr, wen, wdata,
        input  rdata
    );

    modport memory (
        input  addr, wen, wdata,
        output rdata
    );

endinterface

/* verilog/instr_mem.sv */
`timescale 1ns/10ps

module instr_mem (
    input logic clk,
    imem_if.memory mem
);
    import fetch_pkg::*;

    logic [FETCH_PARA-1:0][LEN_INST-1:0] lines [MEM_LINES];
    logic [LEN_MEMISTR_ADDR-1:0] addr_q;

    // per-slot writes at the presented address
    always_ff @(posedge clk) begin
        for (int s = 0; s < FETCH_PARA; s++) begin
            if (mem.wen[s]) begin
                lines[mem.addr][s] <= mem.wdata[s*LEN_INST +: LEN_INST];
            end
        end
    end

    // address register then output register, two edges per read
    always_ff @(posedge clk) begin
        addr_q <= mem.addr;
        mem.rdata <= lines[addr_q];
    end

endmodule

/* verilog/line_cache.sv */
`timescale 1ns/10ps

module line_cache #(
    parameter int PORTS = 1
) (
    input  logic clk,
    input  logic arst_n,
    input  logic flush,
    input  logic fill_valid,
    input  logic [fetch_pkg::LEN_MEMISTR_ADDR-1:0] fill_key,
    input  logic [fetch_pkg::LEN_LINE-1:0] fill_line,
    input  logic [PORTS-1:0] look_valid,
    input  logic [PORTS-1:0][fetch_pkg::LEN_MEMISTR_ADDR-1:0] look_key,
    output logic [PORTS-1:0] hit,
    output logic [PORTS-1:0][fetch_pkg::LEN_LINE-1:0] look_line
);
    import fetch_pkg::*;

    logic [DEPTH_FETCH_CACHE-1:0] valid;
    logic [LEN_MEMISTR_ADDR-1:0] tag [DEPTH_FETCH_CACHE];
    logic [LEN_LINE-1:0] data [DEPTH_FETCH_CACHE];
    logic [LOG_DEPTH_FETCH_CACHE-1:0] victim;
    logic [DEPTH_FETCH_CACHE-1:0] fill_match;
    logic fill_present;
    logic fill_ok;

    // flush wins over a fill in the same cycle
    assign fill_ok = fill_valid & ~flush;

    always_comb begin
        for (int e = 0; e < DEPTH_FETCH_CACHE; e++) begin
            fill_match[e] = valid[e] & (tag[e] == fill_key);
        end
    end

    assign fill_present = |fill_match;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            victim <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (fill_ok && !fill_present) begin
            valid[victim] <= 1'b1;
            victim <= victim + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_ok) begin
            for (int e = 0; e < DEPTH_FETCH_CACHE; e++) begin
                if (fill_match[e]) begin
                    data[e] <= fill_line;
                end
            end
            if (!fill_present) begin
                tag[victim] <= fill_key;
                data[victim] <= fill_line;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < PORTS; p++) begin
            hit[p] = 1'b0;
            look_line[p] = fill_line;
            for (int e = 0; e < DEPTH_FETCH_CACHE; e++) begin
                if (valid[e] && tag[e] == look_key[p]) begin
                    hit[p] = look_valid[p];
                    look_line[p] = data[e];
                end
            end
            // line waiting in the fill register is already usable
            if (fill_ok && fill_key == look_key[p]) begin
                hit[p] = look_valid[p];
                look_line[p] = fill_line;
            end
        end
    end

endmodule

/* verilog/load_if.sv */
`timescale 1ns/10ps

interface load_if;
    import fetch_pkg::*;

    // level high for the whole load session
    logic mode;
    // one cycle per instruction to store
    logic order;
    logic [LEN_WORD-1:0] pc;
    logic [LEN_INST-1:0] data;

    modport loader (
        output mode, order, pc, data
    );

    modport fetch (
        input  mode, order, pc, data
    );

endinterface

/* verilog/prog_loader.sv */
`timescale 1ns/10ps

module prog_loader (
    input  logic clk,
    input  logic arst_n,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [fetch_pkg::LEN_APB_ADDR-1:0] paddr,
    input  logic [fetch_pkg::LEN_WORD-1:0] pwdata,
    output logic [fetch_pkg::LEN_WORD-1:0] prdata,
    output logic pready,
    output logic pslverr,
    load_if.loader load
);
    import fetch_pkg::*;

    logic access;
    logic mapped;
    logic data_wr;
    logic mode_q;
    logic order_q;
    logic [LEN_WORD-1:0] addr_q;
    logic [LEN_WORD-1:0] pc_q;
    logic [LEN_INST-1:0] data_q;

    assign access = psel & penable;
    assign mapped = (paddr == REG_CTRL) | (paddr == REG_ADDR) | (paddr == REG_DATA);
    assign data_wr = access & pwrite & (paddr == REG_DATA);

    assign pready = 1'b1;
    assign pslverr = access & ~mapped;

    // REG_DATA reads back as zero
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                REG_CTRL: prdata = {{(LEN_WORD-1){1'b0}}, mode_q};
                REG_ADDR: prdata = addr_q;
                default:  prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= 1'b0;
            order_q <= 1'b0;
            addr_q <= '0;
        end else begin
            order_q <= data_wr;
            if (access && pwrite && paddr == REG_CTRL) begin
                mode_q <= pwdata[0];
            end
            if (access && pwrite && paddr == REG_ADDR) begin
                addr_q <= pwdata;
            end else if (data_wr) begin
                // auto-increment to the next instruction
                addr_q <= addr_q + LEN_WORD'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            pc_q <= addr_q;
            data_q <= pwdata;
        end
    end

    assign load.mode = mode_q;
    assign load.order = order_q;
    assign load.pc = pc_q;
    assign load.data = data_q;

endmodule
